//--- rv32i_pkg.sv
package rv32i_pkg;

  // ##########################################################################
  // word and field types.
  // ##########################################################################
  typedef logic [31:0] word_t;      // data or address word.
  typedef logic [4:0]  reg_addr_t;  // register index, x0 to x31.
  typedef logic [3:0]  alu_op_t;    // alu operation code.
  typedef logic [1:0]  a_sel_t;     // first alu operand select.
  typedef logic        b_sel_t;     // second alu operand select.
  typedef logic [1:0]  w_sel_t;     // writeback source select.
  typedef logic [2:0]  br_funct_t;  // branch condition, straight from funct3.

  // alu codes follow {funct7[5], funct3} of the op encoding.
  localparam alu_op_t alu_add  = 4'b0000;
  localparam alu_op_t alu_sub  = 4'b1000;
  localparam alu_op_t alu_sll  = 4'b0001;
  localparam alu_op_t alu_slt  = 4'b0010;
  localparam alu_op_t alu_sltu = 4'b0011;
  localparam alu_op_t alu_xor  = 4'b0100;
  localparam alu_op_t alu_srl  = 4'b0101;
  localparam alu_op_t alu_sra  = 4'b1101;
  localparam alu_op_t alu_or   = 4'b0110;
  localparam alu_op_t alu_and  = 4'b0111;

  localparam a_sel_t a_sel_rs1  = 2'd0;  // register operand.
  localparam a_sel_t a_sel_pc   = 2'd1;  // auipc.
  localparam a_sel_t a_sel_zero = 2'd2;  // constant zero.

  localparam b_sel_t b_sel_rs2 = 1'b0;
  localparam b_sel_t b_sel_imm = 1'b1;

  localparam w_sel_t w_sel_alu = 2'd0;  // alu result.
  localparam w_sel_t w_sel_pc4 = 2'd1;  // link address for jal and jalr.
  localparam w_sel_t w_sel_imm = 2'd2;  // lui.

  // branch funct3 codes; 010 and 011 are not defined.
  localparam br_funct_t br_beq  = 3'b000;
  localparam br_funct_t br_bne  = 3'b001;
  localparam br_funct_t br_blt  = 3'b100;
  localparam br_funct_t br_bge  = 3'b101;
  localparam br_funct_t br_bltu = 3'b110;
  localparam br_funct_t br_bgeu = 3'b111;

  // ##########################################################################
  // pipeline structs.
  // ##########################################################################
  typedef struct packed {
    logic  valid;  // slot holds a live instruction.
    word_t instr;
    word_t pc;
    word_t pc4;    // pc + 4, the link value.
  } fetch_exec_t;

  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;        // fully sign-extended immediate.
    alu_op_t   alu_op;
    a_sel_t    a_sel;
    b_sel_t    b_sel;
    w_sel_t    w_sel;
    logic      wb_en;      // instruction writes rd.
    logic      is_branch;
    br_funct_t br_funct;
    logic      is_jal;
    logic      is_jalr;
    logic      illegal;    // encoding not handled by this core.
  } ctrl_t;

endpackage

//--- fetch_execute_reg.sv
`timescale 1ns/1ns

module fetch_execute_reg import rv32i_pkg::*; #(
  parameter word_t reset_pc = 32'h0000_0000  // pc held while in reset.
) (
  input  logic        CLK,
  input  logic        arst_n,
  input  logic        fetch_valid,  // fetch strobe, one word per edge.
  input  word_t       fetch_instr,
  input  word_t       fetch_pc,
  input  logic        redirect,     // execute is leaving the sequential path.
  output fetch_exec_t fe
);

  fetch_exec_t fe_q;  // the stage register itself.
  logic        load;  // a live word is taken this edge.

  // a redirect squashes the word fetched behind the jump or branch.
  assign load = fetch_valid & ~redirect;

  // ##########################################################################
  // fetch to execute register.
  // ##########################################################################
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      fe_q.valid <= 1'b0;        // start with a bubble.
      fe_q.instr <= '0;
      fe_q.pc    <= reset_pc;
      fe_q.pc4   <= '0;
    end else begin
      fe_q.valid <= load;        // missing strobe or redirect gives a bubble.
      if (load) begin
        fe_q.instr <= fetch_instr;
        fe_q.pc    <= fetch_pc;
        fe_q.pc4   <= fetch_pc + 32'd4;  // link address, precomputed here.
      end
    end
  end

  assign fe = fe_q;

endmodule

//--- control_unit.sv
`timescale 1ns/1ns

module control_unit import rv32i_pkg::*; (
  input  word_t instr,  // instruction word in execute.
  output ctrl_t ctrl    // decoded control.
);

  // major opcodes handled here; loads, stores, fence and system are not.
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i, imm_b, imm_u, imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // ##########################################################################
  // immediates, all sign-extended from instr[31].
  // ##########################################################################
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};  // low bits are zero.
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // ##########################################################################
  // main decode.
  // ##########################################################################
  always_comb begin
    ctrl          = '0;            // no write, no redirect, legal.
    ctrl.rs1      = instr[19:15];
    ctrl.rs2      = instr[24:20];
    ctrl.rd       = instr[11:7];   // x0 is left to the register file.
    ctrl.alu_op   = alu_add;
    ctrl.a_sel    = a_sel_zero;
    ctrl.b_sel    = b_sel_rs2;
    ctrl.w_sel    = w_sel_alu;
    ctrl.br_funct = funct3;
    // the illegal branches below never raise wb_en or a redirect flag.
    case (opcode)
      op_lui: begin
        ctrl.imm   = imm_u;
        ctrl.w_sel = w_sel_imm;    // immediate goes straight to rd.
        ctrl.wb_en = 1'b1;
      end
      op_auipc: begin
        ctrl.imm   = imm_u;
        ctrl.a_sel = a_sel_pc;
        ctrl.b_sel = b_sel_imm;
        ctrl.wb_en = 1'b1;
      end
      op_jal: begin
        ctrl.imm    = imm_j;
        ctrl.w_sel  = w_sel_pc4;   // link.
        ctrl.wb_en  = 1'b1;
        ctrl.is_jal = 1'b1;
      end
      op_jalr: begin
        ctrl.imm = imm_i;
        if (funct3 == 3'b000) begin
          ctrl.w_sel   = w_sel_pc4;
          ctrl.wb_en   = 1'b1;
          ctrl.is_jalr = 1'b1;
        end else ctrl.illegal = 1'b1;
      end
      op_branch: begin
        ctrl.imm = imm_b;
        if (funct3[2:1] == 2'b01) ctrl.illegal = 1'b1;  // 010 and 011 unused.
        else ctrl.is_branch = 1'b1;
      end
      op_imm: begin
        ctrl.imm    = imm_i;
        ctrl.a_sel  = a_sel_rs1;
        ctrl.b_sel  = b_sel_imm;
        ctrl.alu_op = {1'b0, funct3};  // no subi.
        if (funct3 == 3'b001 && funct7 != 7'b0000000) begin
          ctrl.illegal = 1'b1;         // slli needs a clean funct7.
        end else if (funct3 == 3'b101 && funct7 != 7'b0000000 &&
                     funct7 != 7'b0100000) begin
          ctrl.illegal = 1'b1;         // only srli and srai.
        end else begin
          ctrl.wb_en = 1'b1;
          if (funct3 == 3'b101) ctrl.alu_op = {funct7[5], funct3};
        end
      end
      op_reg: begin
        ctrl.a_sel  = a_sel_rs1;
        ctrl.alu_op = {funct7[5], funct3};
        // funct7[5] is meaningful only for sub and sra.
        if (funct7 == 7'b0000000 ||
            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          ctrl.wb_en = 1'b1;
        end else ctrl.illegal = 1'b1;
      end
      default: ctrl.illegal = 1'b1;  // loads, stores, fence, ecall and the rest.
    endcase
  end

endmodule

//--- reg_file.sv
`timescale 1ns/1ns

module reg_file import rv32i_pkg::*; (
  input  logic      CLK,
  input  logic      arst_n,
  input  reg_addr_t rs1,       // read port a.
  input  reg_addr_t rs2,       // read port b.
  input  logic      w_en,
  input  reg_addr_t w_addr,
  input  word_t     w_data,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [31:1];  // x0 has no storage.

  // ##########################################################################
  // write port.
  // ##########################################################################
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;  // every register starts at zero.
      end
    end else if (w_en && w_addr != 5'd0) begin
      regs[w_addr] <= w_data;  // writes to x0 fall away here.
    end
  end

  // ##########################################################################
  // read ports, combinational.
  // ##########################################################################
  always_comb begin
    if (rs1 == 5'd0) rs1_data = '0;  // x0 reads zero.
    else rs1_data = regs[rs1];
  end

  always_comb begin
    if (rs2 == 5'd0) rs2_data = '0;
    else rs2_data = regs[rs2];
  end

endmodule

//--- alu.sv
`timescale 1ns/1ns

module alu import rv32i_pkg::*; (
  input  alu_op_t alu_op,
  input  word_t   port_a,
  input  word_t   port_b,
  output word_t   port_out
);

  logic [4:0] shamt;    // shift amount.
  logic       lt_s;     // signed less-than.
  logic       lt_u;     // unsigned less-than.

  assign shamt = port_b[4:0];  // upper bits of port_b are ignored.
  assign lt_s  = $signed(port_a) < $signed(port_b);
  assign lt_u  = port_a < port_b;

  // ##########################################################################
  // operation select.
  // ##########################################################################
  always_comb begin
    case (alu_op)
      alu_add:  port_out = port_a + port_b;
      alu_sub:  port_out = port_a - port_b;
      alu_sll:  port_out = port_a << shamt;
      alu_slt:  port_out = {31'd0, lt_s};
      alu_sltu: port_out = {31'd0, lt_u};
      alu_xor:  port_out = port_a ^ port_b;
      alu_srl:  port_out = port_a >> shamt;
      alu_sra:  port_out = word_t'($signed(port_a) >>> shamt);  // keeps the sign.
      alu_or:   port_out = port_a | port_b;
      alu_and:  port_out = port_a & port_b;
      default:  port_out = '0;  // unused codes.
    endcase
  end

endmodule

//--- branch_jump_unit.sv
`timescale 1ns/1ns

module branch_jump_unit import rv32i_pkg::*; (
  input  word_t     pc,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  input  word_t     imm,          // b, j or i immediate, per instruction.
  input  br_funct_t br_funct,
  output logic      br_taken,     // condition holds.
  output word_t     br_target,
  output word_t     jal_target,
  output word_t     jalr_target
);

  logic  eq;        // operands equal.
  logic  lt_s;      // signed less-than.
  logic  lt_u;      // unsigned less-than.
  word_t pc_rel;    // pc + imm.
  word_t reg_rel;   // rs1 + imm.

  // ##########################################################################
  // compare.
  // ##########################################################################
  assign eq   = rs1_data == rs2_data;
  assign lt_s = $signed(rs1_data) < $signed(rs2_data);
  assign lt_u = rs1_data < rs2_data;

  always_comb begin
    case (br_funct)
      br_beq:  br_taken = eq;
      br_bne:  br_taken = ~eq;
      br_blt:  br_taken = lt_s;
      br_bge:  br_taken = ~lt_s;
      br_bltu: br_taken = lt_u;
      br_bgeu: br_taken = ~lt_u;
      default: br_taken = 1'b0;  // undefined funct3, flagged by decode.
    endcase
  end

  // ##########################################################################
  // targets, computed alongside the compare.
  // ##########################################################################
  assign pc_rel  = pc + imm;
  assign reg_rel = rs1_data + imm;

  assign br_target   = pc_rel;                  // b immediate.
  assign jal_target  = pc_rel;                  // j immediate, same adder.
  assign jalr_target = {reg_rel[31:1], 1'b0};   // bit 0 cleared.

endmodule

//--- execute_stage.sv
`timescale 1ns/1ns

module execute_stage import rv32i_pkg::*; (
  input  logic        CLK,
  input  logic        arst_n,
  input  fetch_exec_t fe,           // instruction in execute.
  output logic        wb_en,
  output reg_addr_t   wb_rd,
  output word_t       wb_data,
  output logic        redirect,     // leave the pc+4 path.
  output word_t       redirect_pc,
  output logic        illegal
);

  ctrl_t ctrl;
  word_t rs1_data, rs2_data;
  word_t port_a, port_b, alu_out;
  logic  br_taken;
  word_t br_target, jal_target, jalr_target;
  word_t wdata;   // writeback value before qualification.

  control_unit u_cu (
    .instr (fe.instr),
    .ctrl  (ctrl)
  );

  reg_file u_rf (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .w_en     (wb_en),      // same strobe as the stage output.
    .w_addr   (wb_rd),
    .w_data   (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // ##########################################################################
  // operands and the two parallel units.
  // ##########################################################################
  always_comb begin
    case (ctrl.a_sel)
      a_sel_rs1:  port_a = rs1_data;
      a_sel_pc:   port_a = fe.pc;   // auipc.
      a_sel_zero: port_a = '0;
      default:    port_a = '0;
    endcase
  end

  assign port_b = (ctrl.b_sel == b_sel_imm) ? ctrl.imm : rs2_data;

  alu u_alu (
    .alu_op   (ctrl.alu_op),
    .port_a   (port_a),
    .port_b   (port_b),
    .port_out (alu_out)
  );

  branch_jump_unit u_bju (
    .pc          (fe.pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (ctrl.imm),
    .br_funct    (ctrl.br_funct),
    .br_taken    (br_taken),
    .br_target   (br_target),
    .jal_target  (jal_target),
    .jalr_target (jalr_target)
  );

  // ##########################################################################
  // writeback and redirect, all qualified by fe.valid.
  // ##########################################################################
  always_comb begin
    case (ctrl.w_sel)
      w_sel_pc4: wdata = fe.pc4;     // link.
      w_sel_imm: wdata = ctrl.imm;   // lui.
      default:   wdata = alu_out;
    endcase
  end

  assign wb_en   = fe.valid & ctrl.wb_en;
  assign wb_rd   = wb_en ? ctrl.rd : '0;
  assign wb_data = wb_en ? wdata : '0;
  assign illegal = fe.valid & ctrl.illegal;

  assign redirect = fe.valid & ((ctrl.is_branch & br_taken) | ctrl.is_jal | ctrl.is_jalr);

  always_comb begin
    if (!redirect) redirect_pc = '0;
    else if (ctrl.is_jalr) redirect_pc = jalr_target;
    else if (ctrl.is_jal) redirect_pc = jal_target;
    else redirect_pc = br_target;   // taken branch.
  end

endmodule

//--- rv32_exec_top.sv
`timescale 1ns/1ns

module rv32_exec_top import rv32i_pkg::*; #(
  parameter word_t reset_pc = 32'h0000_0000  // handed to the fetch register.
) (
  input  logic      CLK,
  input  logic      arst_n,
  input  logic      fetch_valid,
  input  word_t     fetch_instr,
  input  word_t     fetch_pc,
  output logic      wb_en,
  output reg_addr_t wb_rd,
  output word_t     wb_data,
  output logic      redirect,
  output word_t     redirect_pc,
  output logic      illegal
);

  fetch_exec_t fe;  // fetch to execute register contents.

  fetch_execute_reg #(
    .reset_pc (reset_pc)
  ) u_fe_reg (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .fetch_valid (fetch_valid),
    .fetch_instr (fetch_instr),
    .fetch_pc    (fetch_pc),
    .redirect    (redirect),    // squash loops back from execute.
    .fe          (fe)
  );

  execute_stage u_ex (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .fe          (fe),
    .wb_en       (wb_en),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .illegal     (illegal)
  );

endmodule

//--- tb_rv32_exec_top.sv
`timescale 1ns/1ns

module tb_rv32_exec_top import rv32i_pkg::*; ();

  localparam int num_instr      = 2000;  // fetch slots driven.
  localparam int reset_cycles   = 4;
  localparam int timeout_cycles = reset_cycles + num_instr + 96;  // small margin.
  localparam word_t start_pc    = 32'h0000_1000;

  logic      CLK;
  logic      arst_n;
  logic      fetch_valid;
  word_t     fetch_instr;
  word_t     fetch_pc;
  logic      wb_en;
  reg_addr_t wb_rd;
  word_t     wb_data;
  logic      redirect;
  word_t     redirect_pc;
  logic      illegal;

  word_t     model_regs [32];  // architectural registers of the model.
  logic      slot_valid;       // one-deep copy of the execute slot.
  word_t     slot_instr;
  word_t     slot_pc;
  word_t     cur_pc;           // pc handed to fetch next.
  logic      exp_wb_en, exp_redir, exp_ill;
  reg_addr_t exp_rd;
  word_t     exp_data, exp_rpc;
  int        cycle_count;

  rv32_exec_top #(
    .reset_pc (start_pc)
  ) uut (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .fetch_valid (fetch_valid),
    .fetch_instr (fetch_instr),
    .fetch_pc    (fetch_pc),
    .wb_en       (wb_en),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .illegal     (illegal)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;  // 20 ns period.
  end

  initial cycle_count = 0;

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("TEST FAILED");
      $fatal(1, "run did not finish within %0d cycles", timeout_cycles);
    end
  end

  // ##########################################################################
  // reference model.
  // ##########################################################################
  function automatic word_t alu_result(input logic [2:0] f3, input logic alt,
                                       input word_t x, input word_t y);
    logic [4:0] sh;
    sh = y[4:0];  // shifts use the low five bits only.
    case (f3)
      3'd0:    alu_result = alt ? x - y : x + y;
      3'd1:    alu_result = x << sh;
      3'd2:    alu_result = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'd3:    alu_result = (x < y) ? 32'd1 : 32'd0;
      3'd4:    alu_result = x ^ y;
      3'd5:    alu_result = alt ? word_t'($signed(x) >>> sh) : x >> sh;
      3'd6:    alu_result = x | y;
      default: alu_result = x & y;
    endcase
  endfunction

  // expected outputs for one execute slot, from the ISA rules.
  task automatic predict(input logic valid, input word_t instr, input word_t pc);
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      a, b, imm_i, imm_b, imm_u, imm_j;
    logic       taken;
    opcode = instr[6:0];
    f3     = instr[14:12];
    f7     = instr[31:25];
    a      = model_regs[instr[19:15]];
    b      = model_regs[instr[24:20]];
    imm_i  = {{20{instr[31]}}, instr[31:20]};
    imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u  = {instr[31:12], 12'h000};
    imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    taken  = 1'b0;
    exp_wb_en = 1'b0;
    exp_redir = 1'b0;
    exp_ill   = 1'b0;
    exp_rd    = valid ? instr[11:7] : 5'd0;
    exp_data  = '0;
    exp_rpc   = '0;
    if (valid) begin  // a bubble expects all strobes low.
      case (opcode)
        7'h37: begin exp_wb_en = 1'b1; exp_data = imm_u; end       // lui.
        7'h17: begin exp_wb_en = 1'b1; exp_data = pc + imm_u; end  // auipc.
        7'h6f: begin
          exp_wb_en = 1'b1;
          exp_data  = pc + 32'd4;
          exp_redir = 1'b1;
          exp_rpc   = pc + imm_j;
        end
        7'h67: begin
          if (f3 != 3'd0) exp_ill = 1'b1;
          else begin
            exp_wb_en = 1'b1;
            exp_data  = pc + 32'd4;
            exp_redir = 1'b1;
            exp_rpc   = (a + imm_i) & 32'hffff_fffe;  // bit 0 cleared.
          end
        end
        7'h63: begin
          case (f3)
            3'd0:    taken = (a == b);
            3'd1:    taken = (a != b);
            3'd4:    taken = ($signed(a) < $signed(b));
            3'd5:    taken = ($signed(a) >= $signed(b));
            3'd6:    taken = (a < b);
            3'd7:    taken = (a >= b);
            default: exp_ill = 1'b1;
          endcase
          exp_redir = taken;
          exp_rpc   = taken ? pc + imm_b : 32'd0;
        end
        7'h13: begin
          if ((f3 == 3'd1 && f7 != 7'h00) ||
              (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)) exp_ill = 1'b1;
          else begin
            exp_wb_en = 1'b1;
            exp_data  = alu_result(f3, f3 == 3'd5 && f7[5], a, imm_i);
          end
        end
        7'h33: begin
          if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
            exp_wb_en = 1'b1;
            exp_data  = alu_result(f3, f7[5], a, b);
          end else exp_ill = 1'b1;
        end
        default: exp_ill = 1'b1;  // loads, stores, fence, system.
      endcase
    end
    if (!exp_wb_en) exp_rd = 5'd0;
  endtask

  // ##########################################################################
  // stimulus and checking.
  // ##########################################################################
  function automatic word_t random_instr();
    word_t      t, w;
    reg_addr_t  rd, rs1, rs2;
    logic [2:0] f3, bf;
    logic [6:0] f7;
    int         cls;
    t   = $urandom;
    w   = $urandom;
    rd  = {2'b00, w[2:0]};  // x0..x7, so results get read back often.
    rs1 = {2'b00, w[5:3]};
    rs2 = {2'b00, w[8:6]};
    f3  = w[11:9];
    f7  = ((f3 == 3'd0 || f3 == 3'd5) && w[12]) ? 7'h20 : 7'h00;
    cls = $urandom % 100;
    case ($urandom % 6)
      0:       bf = 3'd0;
      1:       bf = 3'd1;
      2:       bf = 3'd4;
      3:       bf = 3'd5;
      4:       bf = 3'd6;
      default: bf = 3'd7;
    endcase
    if (cls < 25) random_instr = {f7, rs2, rs1, f3, rd, 7'h33};
    else if (cls < 50) begin
      if (f3 == 3'd1 || f3 == 3'd5) random_instr = {f7, t[24:20], rs1, f3, rd, 7'h13};
      else random_instr = {t[31:20], rs1, f3, rd, 7'h13};
    end
    else if (cls < 58) random_instr = {t[31:12], rd, 7'h37};
    else if (cls < 65) random_instr = {t[31:12], rd, 7'h17};
    else if (cls < 80) random_instr = {t[31:25], rs2, rs1, bf, t[11:7], 7'h63};
    else if (cls < 87) random_instr = {t[31:12], rd, 7'h6f};
    else if (cls < 95) random_instr = {t[31:20], rs1, 3'b000, rd, 7'h67};
    else begin
      case ($urandom % 6)  // encodings outside this core.
        0:       random_instr = {t[31:7], 7'h03};
        1:       random_instr = {t[31:7], 7'h23};
        2:       random_instr = {t[31:7], 7'h0f};
        3:       random_instr = {t[31:7], 7'h73};
        4:       random_instr = {t[31:15], 2'b01, t[12:7], 7'h63};  // funct3 01x.
        default: random_instr = {7'h01, rs2, rs1, f3, rd, 7'h33};  // m extension.
      endcase
    end
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "output %s does not match the model", name);
    end
  endtask

  task automatic check_outputs();
    predict(slot_valid, slot_instr, slot_pc);
    check_value("wb_en", {31'd0, wb_en}, {31'd0, exp_wb_en});
    check_value("redirect", {31'd0, redirect}, {31'd0, exp_redir});
    check_value("illegal", {31'd0, illegal}, {31'd0, exp_ill});
    // data outputs read zero whenever their strobe is low.
    check_value("wb_rd", {27'd0, wb_rd}, {27'd0, exp_rd});
    check_value("wb_data", wb_data, exp_data);
    check_value("redirect_pc", redirect_pc, exp_rpc);
  endtask

  initial begin
    void'($urandom(63));
    arst_n      = 1'b0;
    fetch_valid = 1'b0;
    fetch_instr = '0;
    fetch_pc    = '0;
    slot_valid  = 1'b0;  // pipeline starts empty.
    slot_instr  = '0;
    slot_pc     = '0;
    cur_pc      = start_pc;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    repeat (reset_cycles) @(posedge CLK);
    @(negedge CLK);
    arst_n = 1'b1;
    for (int n = 0; n < num_instr; n++) begin
      check_outputs();
      if (exp_wb_en && exp_rd != 5'd0) model_regs[exp_rd] = exp_data;  // x0 stays zero.
      fetch_valid = ($urandom % 100) < 80;
      fetch_instr = random_instr();
      fetch_pc    = cur_pc;
      slot_valid  = fetch_valid && !exp_redir;  // squashed behind a redirect.
      slot_instr  = fetch_instr;
      slot_pc     = fetch_pc;
      if (exp_redir) cur_pc = exp_rpc;
      else if (fetch_valid) cur_pc = cur_pc + 32'd4;
      @(negedge CLK);
    end
    check_outputs();  // last slot still in execute.
    $display("TEST OK");
    $finish;
  end

endmodule

//--- sources.f
rv32i_pkg.sv
fetch_execute_reg.sv
control_unit.sv
reg_file.sv
alu.sv
branch_jump_unit.sv
execute_stage.sv
rv32_exec_top.sv
tb_rv32_exec_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with verilator; exit status follows the simulation.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_rv32_exec_top \
  -Mdir obj_dir \
  -f sources.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_rv32_exec_top
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0
